//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = tb_approx_div
FILELIST  = build.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf $(BUILD_DIR)

//--- approx_div_macros.svh
`ifndef APPROX_DIV_MACROS_SVH
`define APPROX_DIV_MACROS_SVH

`define APPROX_DIV_REQ_DEPTH 4    // Request slots, also initial sender credits.
`define APPROX_DIV_OUT_DEPTH 4    // Result FIFO slots.
`define APPROX_DIV_OUT_CREDITS 2  // Initial consumer grant.
`define APPROX_DIV_APPROX_ROWS 4  // Low quotient rows on approximate cells.

`endif

//--- approx_div_pkg.sv
package approx_div_pkg;

  // 16-bit dividend.
  typedef logic [15:0] numer_t;

  // 8-bit divisor.
  typedef logic [7:0] denom_t;

  // Quotient and remainder share one width.
  typedef logic [7:0] quot_t;

  // Counts credits and FIFO occupancy, 0 to 7.
  typedef logic [2:0] credit_cnt_t;

endpackage

//--- approx_div_stimulus.txt
// numer denom quot rem exact : hex, one case per line
// quot and rem are the approximate array results, exact is 1 when they match true division
0000 01 0F 01 00
0001 01 0F 03 00
00A5 01 AF 03 00
00FF 01 FF 03 00
0030 01 3F 01 00
007E 01 7F 01 00
0000 02 0F 02 00
01FF 02 FF 02 00
0123 02 9F 02 00
0080 02 4F 02 00
0100 03 5F 07 00
02FF 03 FF 07 00
0005 03 0F 07 00
0200 03 AF 07 00
03FF 04 FF 04 00
0155 04 5F 04 00
0000 05 0F 05 00
0003 05 0F 0F 00
04FE 05 FF 0D 00
0231 05 7F 07 00
0400 06 AF 0E 00
05FF 06 FF 0E 00
0600 07 DF 0F 00
0123 07 2F 0F 00
0811 09 EF 0B 00
0470 09 7F 09 00
09FF 0A FF 0A 00
0321 0A 5F 0A 00
0B80 0C FF 1C 00
0600 0C 8F 1C 00
0E00 0F EF 1F 00
0ABC 0F BF 1F 00
0FFF 10 FF 10 00
0765 10 7F 10 00
1000 11 FF 11 00
0333 11 3F 13 00
1FFF 20 FF 20 00
0A0A 20 5F 20 00
2F00 30 FF 70 00
1234 30 6F 70 00
3ABC 40 EF 40 00
5400 55 FF 55 00
123F 55 3F FF 00
2A05 55 7F 77 00
7E00 7F FF FF 00
0100 7F 0F FF 00
7FFF 80 F7 80 00
1234 80 2F 80 00
0400 80 07 80 00
BF00 C0 FF C0 00
0500 C0 07 C0 00
1000 C0 17 C0 00
2000 C0 2F C0 00
FE00 FF FF FF 00
0700 FF 07 FF 00
1300 FF 1F FF 00

//--- approx_div_unit.sv
`include "approx_div_macros.svh"

module approx_div_unit (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_valid,
  input  approx_div_pkg::numer_t in_numer,
  input  approx_div_pkg::denom_t in_denom,
  output logic                   in_credit,
  output logic                   out_valid,
  output approx_div_pkg::quot_t  out_quot,
  output approx_div_pkg::quot_t  out_rem,
  input  logic                   out_credit
);

  logic                   head_valid;
  approx_div_pkg::numer_t head_numer;
  approx_div_pkg::denom_t head_denom;
  logic                   issue_ok;
  logic                   pop;

  logic                   issue_valid;
  approx_div_pkg::numer_t issue_numer;
  approx_div_pkg::denom_t issue_denom;
  approx_div_pkg::quot_t  arr_quot;
  approx_div_pkg::quot_t  arr_rem;

  assign pop = head_valid & issue_ok;

  div_req_queue u_req_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_numer   (in_numer),
    .in_denom   (in_denom),
    .pop        (pop),
    .head_valid (head_valid),
    .head_numer (head_numer),
    .head_denom (head_denom),
    .in_credit  (in_credit)
  );

  // Held item drains into the FIFO at the next edge.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      issue_numer <= head_numer;
      issue_denom <= head_denom;
    end
  end

  div_array #(
    .approx_rows (`APPROX_DIV_APPROX_ROWS)
  ) u_array (
    .numer (issue_numer),
    .denom (issue_denom),
    .quot  (arr_quot),
    .rem   (arr_rem)
  );

  div_out_stage u_out_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .res_valid  (issue_valid),
    .res_quot   (arr_quot),
    .res_rem    (arr_rem),
    .in_flight  (issue_valid),  // Only the issue register is in flight.
    .issue_ok   (issue_ok),
    .out_valid  (out_valid),
    .out_quot   (out_quot),
    .out_rem    (out_rem),
    .out_credit (out_credit)
  );

endmodule

//--- build.f
+incdir+.
approx_div_pkg.sv
div_cell.sv
div_array.sv
div_req_queue.sv
div_out_stage.sv
approx_div_unit.sv
tb_approx_div.sv

//--- div_array.sv
module div_array #(
  parameter int approx_rows = 4
) (
  input  approx_div_pkg::numer_t numer,
  input  approx_div_pkg::denom_t denom,
  output approx_div_pkg::quot_t  quot,
  output approx_div_pkg::quot_t  rem
);

  // Row i produces quotient bit i; row 7 is evaluated first.
  logic [7:0] x_row [8];  // Minuend bits into each row.
  logic [7:0] r_row [8];  // Partial remainder out of each row.
  logic [7:0] b_row [8];  // Borrow out of each cell.
  logic [7:0] b_in  [8];  // Borrow into each cell.
  logic [7:0] top;        // Bit above the row's minuend.
  logic [7:0] q_bits;

  for (genvar i = 0; i < 8; i++) begin : g_row
    if (i == 7) begin : g_first
      assign x_row[i] = numer[14:7];
      assign top[i]   = numer[15];
    end else begin : g_next
      assign x_row[i] = {r_row[i+1][6:0], numer[i]};  // Shift in next dividend bit.
      assign top[i]   = r_row[i+1][7];
    end

    assign b_in[i]   = {b_row[i][6:0], 1'b0};
    assign q_bits[i] = top[i] | ~b_row[i][7];

    for (genvar j = 0; j < 8; j++) begin : g_col
      div_cell #(
        .approx (i < approx_rows)
      ) u_cell (
        .x     (x_row[i][j]),
        .y     (denom[j]),
        .bin   (b_in[i][j]),
        .qs    (q_bits[i]),
        .r_sub (r_row[i][j]),
        .bout  (b_row[i][j])
      );
    end
  end

  assign quot = q_bits;
  assign rem  = r_row[0];  // Bottom row holds the final remainder.

endmodule

//--- div_cell.sv
module div_cell #(
  parameter bit approx = 1'b0
) (
  input  logic x,
  input  logic y,
  input  logic bin,
  input  logic qs,
  output logic r_sub,
  output logic bout
);

  logic diff;

  if (approx) begin : g_approx
    // Reduced difference and borrow forms.
    assign diff = y | bin;
    assign bout = x & y;
  end else begin : g_exact
    assign diff = x ^ y ^ bin;
    assign bout = (~x & y) | (~(x ^ y) & bin);
  end

  assign r_sub = qs ? diff : x;  // Restore on failed subtract.

endmodule

//--- div_out_stage.sv
`include "approx_div_macros.svh"

module div_out_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  res_valid,
  input  approx_div_pkg::quot_t res_quot,
  input  approx_div_pkg::quot_t res_rem,
  input  logic                  in_flight,
  output logic                  issue_ok,
  output logic                  out_valid,
  output approx_div_pkg::quot_t out_quot,
  output approx_div_pkg::quot_t out_rem,
  input  logic                  out_credit
);

  localparam int ptr_w = $clog2(`APPROX_DIV_OUT_DEPTH);
  localparam logic [ptr_w-1:0] last_ptr = ptr_w'(`APPROX_DIV_OUT_DEPTH - 1);
  localparam approx_div_pkg::credit_cnt_t depth =
    approx_div_pkg::credit_cnt_t'(`APPROX_DIV_OUT_DEPTH);

  approx_div_pkg::quot_t quot_mem [`APPROX_DIV_OUT_DEPTH];
  approx_div_pkg::quot_t rem_mem  [`APPROX_DIV_OUT_DEPTH];

  logic [ptr_w-1:0]            wr_ptr;
  logic [ptr_w-1:0]            rd_ptr;
  approx_div_pkg::credit_cnt_t count;
  approx_div_pkg::credit_cnt_t credits;
  approx_div_pkg::credit_cnt_t reserved;
  logic                        send;

  assign send = (count != '0) && (credits != '0);

  // Issue register item needs a slot of its own.
  assign reserved = count + approx_div_pkg::credit_cnt_t'(in_flight);
  assign issue_ok = (reserved < depth);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      credits <= approx_div_pkg::credit_cnt_t'(`APPROX_DIV_OUT_CREDITS);
    end else begin
      if (res_valid) begin
        wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
      end
      if (send) begin
        rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
      end
      count   <= count + approx_div_pkg::credit_cnt_t'(res_valid)
                       - approx_div_pkg::credit_cnt_t'(send);
      // Spend and return may coincide.
      credits <= credits + approx_div_pkg::credit_cnt_t'(out_credit)
                         - approx_div_pkg::credit_cnt_t'(send);
    end
  end

  always_ff @(posedge clk) begin
    if (res_valid) begin
      quot_mem[wr_ptr] <= res_quot;
      rem_mem[wr_ptr]  <= res_rem;
    end
  end

  assign out_valid = send;
  assign out_quot  = quot_mem[rd_ptr];
  assign out_rem   = rem_mem[rd_ptr];

endmodule

//--- div_req_queue.sv
`include "approx_div_macros.svh"

module div_req_queue (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_valid,
  input  approx_div_pkg::numer_t in_numer,
  input  approx_div_pkg::denom_t in_denom,
  input  logic                   pop,
  output logic                   head_valid,
  output approx_div_pkg::numer_t head_numer,
  output approx_div_pkg::denom_t head_denom,
  output logic                   in_credit
);

  localparam int ptr_w = $clog2(`APPROX_DIV_REQ_DEPTH);
  localparam logic [ptr_w-1:0] last_ptr = ptr_w'(`APPROX_DIV_REQ_DEPTH - 1);

  approx_div_pkg::numer_t numer_mem [`APPROX_DIV_REQ_DEPTH];
  approx_div_pkg::denom_t denom_mem [`APPROX_DIV_REQ_DEPTH];

  logic [ptr_w-1:0]            wr_ptr;
  logic [ptr_w-1:0]            rd_ptr;
  approx_div_pkg::credit_cnt_t count;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      in_credit <= 1'b0;
    end else begin
      if (in_valid) begin
        wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
      end
      count     <= count + approx_div_pkg::credit_cnt_t'(in_valid)
                         - approx_div_pkg::credit_cnt_t'(pop);
      in_credit <= pop;  // One credit back per freed slot.
    end
  end

  // Sender credits guarantee a free slot on every write.
  always_ff @(posedge clk) begin
    if (in_valid) begin
      numer_mem[wr_ptr] <= in_numer;
      denom_mem[wr_ptr] <= in_denom;
    end
  end

  assign head_valid = (count != '0);
  assign head_numer = numer_mem[rd_ptr];
  assign head_denom = denom_mem[rd_ptr];

endmodule

//--- tb_approx_div.sv
`include "approx_div_macros.svh"

module tb_approx_div;

  localparam int num_cases  = 56;
  localparam int words      = 5;     // numer, denom, quot, rem, exact flag.
  localparam int wait_limit = 200;   // Cycles.
  localparam int drive_dly  = 10;
  localparam int hold_win   = 30;    // Cycles watched with credits held.

  logic                   clk;
  logic                   rst_n;
  logic                   in_valid;
  approx_div_pkg::numer_t in_numer;
  approx_div_pkg::denom_t in_denom;
  logic                   in_credit;
  logic                   out_valid;
  approx_div_pkg::quot_t  out_quot;
  approx_div_pkg::quot_t  out_rem;
  logic                   out_credit;

  logic [15:0] stim_mem [0:num_cases*words-1];
  int          exp_q [$];            // Case indices in send order.

  integer seed;
  int     err_count;
  int     exact_errs;
  int     exact_cmp;
  int     sent;
  int     beats;
  int     returned;
  int     pending_returns;
  int     credit_pulses;
  int     sender_credits;
  logic   hold_credits;

  approx_div_unit dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_numer   (in_numer),
    .in_denom   (in_denom),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_quot   (out_quot),
    .out_rem    (out_rem),
    .out_credit (out_credit)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  task automatic abort_run(input string why);
    $display("Run stopped at %0t: %s", $time, why);
    $display("Counts: %0d sent, %0d results, %0d errors", sent, beats, err_count);
    $display("Something failed");
    $finish;
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      $display("%s: passed", name);
    end else begin
      $display("%s: failed with %0d errors", name, err_count - errs_before);
    end
  endtask

  // Compares one output beat with the oldest outstanding request.
  task automatic check_result();
    int          idx;
    logic [15:0] n;
    logic [15:0] d;
    logic [15:0] exact_quot;
    logic [15:0] exact_rem;
    if (exp_q.size() == 0) begin
      $display("At %0t a result came out with no request outstanding", $time);
      err_count++;
    end else begin
      idx        = exp_q.pop_front();
      n          = stim_mem[idx*words];
      d          = stim_mem[idx*words+1];
      exact_quot = n / d;
      exact_rem  = n % d;
      if (out_quot !== stim_mem[idx*words+2][7:0]) begin
        $display("ERROR at %0t: out_quot expected %h got %h (case %0d)",
                 $time, stim_mem[idx*words+2][7:0], out_quot, idx);
        err_count++;
      end
      if (out_rem !== stim_mem[idx*words+3][7:0]) begin
        $display("ERROR at %0t: out_rem expected %h got %h (case %0d)",
                 $time, stim_mem[idx*words+3][7:0], out_rem, idx);
        err_count++;
      end
      // Rows 4 to 7 are exact cells.
      exact_cmp++;
      if (out_quot[7:4] !== exact_quot[7:4]) begin
        $display("ERROR at %0t: out_quot[7:4] expected %h got %h (case %0d)",
                 $time, exact_quot[7:4], out_quot[7:4], idx);
        err_count++;
        exact_errs++;
      end
      if (stim_mem[idx*words+4] != 16'h0) begin
        if (out_quot !== exact_quot[7:0] || out_rem !== exact_rem[7:0]) begin
          $display("ERROR at %0t: out_quot/out_rem expected %h/%h got %h/%h (case %0d)",
                   $time, exact_quot[7:0], exact_rem[7:0], out_quot, out_rem, idx);
          err_count++;
          exact_errs++;
        end
      end
    end
    beats++;
    pending_returns++;
    if (beats - returned > `APPROX_DIV_OUT_CREDITS) begin
      $display("At %0t more results arrived than the consumer granted credits", $time);
      err_count++;
    end
  endtask

  // Outputs sampled mid-cycle.
  initial begin
    forever begin
      @(negedge clk);
      if (rst_n) begin
        if (out_valid) begin
          check_result();
        end
        if (in_credit) begin
          credit_pulses++;
          sender_credits++;
        end
      end
    end
  end

  // Consumer returns one credit per received beat after a random gap.
  initial begin
    forever begin
      @(posedge clk);
      #drive_dly;
      out_credit = 1'b0;
      if (!hold_credits && pending_returns > 0 && ($random(seed) & 3) != 0) begin
        out_credit = 1'b1;
        pending_returns--;
        returned++;
      end
    end
  end

  task automatic send_req(input int idx, input int gap_max);
    int waited;
    int gap;
    gap    = $unsigned($random(seed)) % (gap_max + 1);
    waited = 0;
    repeat (gap) begin
      @(posedge clk);
      #drive_dly;
    end
    while (sender_credits == 0) begin
      if (waited == wait_limit) begin
        abort_run("sender never got a request credit back");
      end
      @(posedge clk);
      #drive_dly;
      waited++;
    end
    in_valid = 1'b1;
    in_numer = stim_mem[idx*words];
    in_denom = stim_mem[idx*words+1][7:0];
    sender_credits--;
    sent++;
    exp_q.push_back(idx);
    @(posedge clk);
    #drive_dly;
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (beats != sent || pending_returns != 0) begin
      if (waited == wait_limit) begin
        abort_run("results did not drain in time");
      end
      @(posedge clk);
      #drive_dly;
      waited++;
    end
  endtask

  // File flags must agree with plain integer division.
  task automatic check_file_flags();
    logic [15:0] n;
    logic [15:0] d;
    logic        match;
    for (int i = 0; i < num_cases; i++) begin
      n     = stim_mem[i*words];
      d     = stim_mem[i*words+1];
      match = ((n / d) == stim_mem[i*words+2]) && ((n % d) == stim_mem[i*words+3]);
      if (match != (stim_mem[i*words+4] != 16'h0)) begin
        $display("Case %0d has an exact flag that disagrees with the division", i);
        err_count++;
        exact_errs++;
      end
    end
  endtask

  initial begin
    int errs;
    int phase_beats;
    seed            = 32'h1fa20c2f;
    rst_n           = 1'b0;
    in_valid        = 1'b0;
    in_numer        = '0;
    in_denom        = '0;
    out_credit      = 1'b0;
    hold_credits    = 1'b0;
    err_count       = 0;
    exact_errs      = 0;
    exact_cmp       = 0;
    sent            = 0;
    beats           = 0;
    returned        = 0;
    pending_returns = 0;
    credit_pulses   = 0;
    sender_credits  = `APPROX_DIV_REQ_DEPTH;

    $readmemh("approx_div_stimulus.txt", stim_mem);
    if ($isunknown(stim_mem[num_cases*words-4]) ||
        stim_mem[num_cases*words-4] == 16'h0) begin
      abort_run("stimulus file missing or short");
    end
    check_file_flags();

    repeat (3) @(posedge clk);
    #drive_dly;
    rst_n = 1'b1;

    errs = err_count;
    for (int c = 0; c < 20; c++) begin
      @(negedge clk);
      if (out_valid !== 1'b0) begin
        $display("ERROR at %0t: out_valid expected 0 got %b", $time, out_valid);
        err_count++;
      end
      if (in_credit !== 1'b0) begin
        $display("ERROR at %0t: in_credit expected 0 got %b", $time, in_credit);
        err_count++;
      end
    end
    @(posedge clk);
    #drive_dly;
    report_test("idle after reset", errs);

    errs = err_count;
    for (int i = 0; i < `APPROX_DIV_REQ_DEPTH; i++) begin
      send_req(i, 0);
    end
    wait_drain();
    if (credit_pulses != sent) begin
      $display("ERROR at %0t: in_credit pulses expected %0d got %0d",
               $time, sent, credit_pulses);
      err_count++;
    end
    report_test("upstream credit burst", errs);

    errs = err_count;
    for (int i = `APPROX_DIV_REQ_DEPTH; i < 48; i++) begin
      send_req(i, 3);
    end
    wait_drain();
    report_test("random stream", errs);

    errs        = err_count;
    hold_credits = 1'b1;
    phase_beats = beats;
    for (int i = 48; i < num_cases; i++) begin
      send_req(i, 0);
    end
    for (int c = 0; c < hold_win; c++) begin
      @(posedge clk);
    end
    #drive_dly;
    if (beats - phase_beats > `APPROX_DIV_OUT_CREDITS) begin
      $display("ERROR at %0t: results while held expected at most %0d got %0d",
               $time, `APPROX_DIV_OUT_CREDITS, beats - phase_beats);
      err_count++;
    end
    hold_credits = 1'b0;
    wait_drain();
    if (credit_pulses != sent) begin
      $display("ERROR at %0t: in_credit pulses expected %0d got %0d",
               $time, sent, credit_pulses);
      err_count++;
    end
    report_test("downstream back-pressure", errs);

    if (exact_errs == 0) begin
      $display("exact arithmetic cross-check: passed over %0d results", exact_cmp);
    end else begin
      $display("exact arithmetic cross-check: failed with %0d errors", exact_errs);
    end

    $display("Counts: %0d sent, %0d results, %0d errors", sent, beats, err_count);
    if (err_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
